// File: all.f
source/fixp_pkg.sv
source/persp_pkg.sv
source/fix_mul.sv
source/fix_div.sv
source/system_builder.sv
source/solve_ctrl.sv
source/pivot_normalizer.sv
source/elim_lane.sv
source/solution_collect.sv
source/persp_solver.sv
dv/tb_persp_solver.sv

// File: dv/tb_persp_solver.sv
module tb_persp_solver;
    import fixp_pkg::*;
    import persp_pkg::*;

    localparam int CLK_T    = 8;
    localparam int RST_CYC  = 16;
    localparam int N_RANDOM = 200;
    // identity square, busy restart and degenerate quad on top of the random ones
    localparam int N_SOLVES = N_RANDOM + 3;

    logic  i_clk;
    logic  i_rst_n;
    logic  i_start;
    quad_t i_quad;
    coef_t o_coef;
    logic  o_valid;

    logic [31:0] lcg_state;
    fix_t        mdl [N_UNK][N_COL];

    persp_solver uut (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (i_start),
        .i_quad  (i_quad),
        .o_coef  (o_coef),
        .o_valid (o_valid)
    );

    always #(CLK_T / 2) i_clk = ~i_clk;

    function automatic coord_t rand_coord();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return coord_t'(lcg_state[25:16]);
    endfunction

    function automatic point_t make_point(input int x, input int y);
        point_t p;
        p.x = coord_t'(x);
        p.y = coord_t'(y);
        return p;
    endfunction

    function automatic quad_t rand_quad();
        quad_t q;
        q.ul = make_point(rand_coord(), rand_coord());
        q.ur = make_point(rand_coord(), rand_coord());
        q.dr = make_point(rand_coord(), rand_coord());
        q.dl = make_point(rand_coord(), rand_coord());
        return q;
    endfunction

    function automatic fix_t int_fix(input int n);
        return fix_t'(n) <<< FRAC_W;
    endfunction

    // full product, floor shift, saturate when outside the fix_t range
    function automatic fix_t mul_model(input fix_t a, input fix_t b);
        logic signed [79:0] aw;
        logic signed [79:0] bw;
        logic signed [79:0] s;
        logic signed [79:0] hi;
        logic signed [79:0] lo;
        aw = a;
        bw = b;
        hi = FIX_MAX;
        lo = FIX_MIN;
        s  = (aw * bw) >>> FRAC_W;
        if (s > hi || s < lo) begin
            return ((a < 0) != (b < 0)) ? FIX_MIN : FIX_MAX;
        end
        return s[FIX_W-1:0];
    endfunction

    function automatic fix_t div_model(input fix_t n, input fix_t d);
        logic signed [79:0] nw;
        logic signed [79:0] dw;
        logic signed [79:0] q;
        logic signed [79:0] hi;
        logic signed [79:0] lo;
        nw = n;
        dw = d;
        hi = FIX_MAX;
        lo = FIX_MIN;
        if (d == 0) begin
            return (n < 0) ? FIX_MIN : FIX_MAX;
        end
        q = (nw <<< FRAC_W) / dw;
        if (q > hi || q < lo) begin
            return ((n < 0) != (d < 0)) ? FIX_MIN : FIX_MAX;
        end
        return q[FIX_W-1:0];
    endfunction

    // one equation of a corner mapped to destination (u, v)
    task automatic set_eq(input int lane, input point_t p, input bit is_y,
                          input int u, input int v);
        int s;
        int base;
        s    = is_y ? int'(p.y) : int'(p.x);
        base = is_y ? 3 : 0;
        for (int j = 0; j < N_COL; j++) begin
            mdl[lane][j] = '0;
        end
        mdl[lane][base]     = int_fix(u);
        mdl[lane][base + 1] = int_fix(v);
        mdl[lane][base + 2] = int_fix(1);
        mdl[lane][6]        = int_fix(-u * s);
        mdl[lane][7]        = int_fix(-v * s);
        mdl[lane][RHS_COL]  = int_fix(s);
    endtask

    task automatic model_solve(input quad_t q, output coef_t c);
        fix_t nrow [N_COL];
        fix_t factor;
        set_eq(0, q.ur, 1'b0, DST_SIZE, 0);
        set_eq(1, q.dl, 1'b0, 0, DST_SIZE);
        set_eq(2, q.ul, 1'b0, 0, 0);
        set_eq(3, q.ur, 1'b1, DST_SIZE, 0);
        set_eq(4, q.dl, 1'b1, 0, DST_SIZE);
        set_eq(5, q.ul, 1'b1, 0, 0);
        set_eq(6, q.dr, 1'b0, DST_SIZE, DST_SIZE);
        set_eq(7, q.dr, 1'b1, DST_SIZE, DST_SIZE);
        for (int k = 0; k < N_UNK; k++) begin
            for (int j = 0; j < N_COL; j++) begin
                nrow[j] = div_model(mdl[k][j], mdl[k][k]);
            end
            nrow[k] = FIX_ONE;
            for (int i = 0; i < N_UNK; i++) begin
                factor = mdl[i][k];
                for (int j = 0; j < N_COL; j++) begin
                    mdl[i][j] = (i == k) ? nrow[j] : mdl[i][j] - mul_model(factor, nrow[j]);
                end
                if (i != k) begin
                    mdl[i][k] = '0;
                end
            end
        end
        c.a = mdl[0][RHS_COL];
        c.b = mdl[1][RHS_COL];
        c.c = mdl[2][RHS_COL];
        c.d = mdl[3][RHS_COL];
        c.e = mdl[4][RHS_COL];
        c.f = mdl[5][RHS_COL];
        c.g = mdl[6][RHS_COL];
        c.h = mdl[7][RHS_COL];
    endtask

    task automatic fail_now();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_coef(input coef_t exp_c, input coef_t act_c);
        fix_t [N_UNK-1:0] ev;
        fix_t [N_UNK-1:0] av;
        string            letters;
        logic             bad;
        ev      = exp_c;
        av      = act_c;
        letters = "abcdefgh";
        bad     = 1'b0;
        // field a is the top word of the struct
        for (int i = 0; i < N_UNK; i++) begin
            if (av[N_UNK-1-i] !== ev[N_UNK-1-i]) begin
                $display("** Error at %0t: o_coef.%c expected %0d, actual %0d",
                         $time, letters[i], ev[N_UNK-1-i], av[N_UNK-1-i]);
                bad = 1'b1;
            end
        end
        if (bad) begin
            fail_now();
        end
    endtask

    task automatic check_valid(input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("** Error at %0t: o_valid expected %0b, actual %0b", $time, exp_v, act_v);
            fail_now();
        end
    endtask

    // called 1 unit after a rising edge; o_valid must appear 9 edges after the start edge
    task automatic run_solve(input quad_t q, input logic late_start, input quad_t q2);
        coef_t exp_c;
        model_solve(q, exp_c);
        i_quad  = q;
        i_start = 1'b1;
        @(posedge i_clk);
        #1;
        i_start = 1'b0;
        for (int n = 1; n <= 9; n++) begin
            @(posedge i_clk);
            #1;
            check_valid(n == 9, o_valid);
            if (late_start && n == 2) begin
                i_quad  = q2;
                i_start = 1'b1;
            end
            if (late_start && n == 3) begin
                i_start = 1'b0;
            end
        end
        check_coef(exp_c, o_coef);
        @(posedge i_clk);
        #1;
        check_valid(1'b0, o_valid);
        if (late_start) begin
            repeat (12) begin
                @(posedge i_clk);
                #1;
                check_valid(1'b0, o_valid);
                check_coef(exp_c, o_coef);
            end
        end
    endtask

    initial begin
        quad_t q1;
        quad_t q2;
        coef_t zero_c;
        i_clk     = 1'b0;
        i_rst_n   = 1'b0;
        i_start   = 1'b0;
        i_quad    = '0;
        lcg_state = 32'd25;
        zero_c    = '0;
        repeat (RST_CYC) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        @(posedge i_clk);
        #1;
        check_valid(1'b0, o_valid);
        check_coef(zero_c, o_coef);

        // square is a parallelogram, so lane 6 meets a zero pivot in column g
        q1.ul = make_point(0, 0);
        q1.ur = make_point(DST_SIZE, 0);
        q1.dr = make_point(DST_SIZE, DST_SIZE);
        q1.dl = make_point(0, DST_SIZE);
        run_solve(q1, 1'b0, q1);

        for (int t = 0; t < N_RANDOM; t++) begin
            q1 = rand_quad();
            run_solve(q1, 1'b0, q1);
        end

        // start while busy is ignored
        q1 = rand_quad();
        q2 = rand_quad();
        if (q2 == q1) begin
            q2.ul.x = q1.ul.x + 1'b1;
        end
        run_solve(q1, 1'b1, q2);

        // all corners equal
        q1.ul = make_point(517, 263);
        q1.ur = q1.ul;
        q1.dr = q1.ul;
        q1.dl = q1.ul;
        run_solve(q1, 1'b0, q1);

        $display("Test OK");
        $finish;
    end

    initial begin
        #((N_SOLVES * 16 + RST_CYC) * CLK_T);
        $display("watchdog expired before all solves finished");
        $display("Test FAILED");
        $fatal(1);
    end

endmodule

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_persp_solver -f all.f -o tb_sim &&
./obj_dir/tb_sim > sim.log 2>&1 || echo "simulation ended with an error"
cat sim.log 2>/dev/null
grep -qx "Test OK" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

// File: source/elim_lane.sv
module elim_lane (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  persp_pkg::lane_op_e i_op,
    input  persp_pkg::step_t    i_step,
    input  persp_pkg::row_t     i_load,
    input  persp_pkg::row_t     i_norm,
    output persp_pkg::row_t     o_row
);
    import fixp_pkg::*;
    import persp_pkg::*;

    row_t row_q;
    row_t prod;
    fix_t factor;

    // this row's entry in the pivot column scales the pivot row
    assign factor = row_q[i_step];

    for (genvar j = 0; j < N_COL; j++) begin : g_mul
        fix_mul u_mul (
            .i_a (factor),
            .i_b (i_norm[j]),
            .o_p (prod[j])
        );
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            row_q <= '0;
        end else begin
            case (i_op)
                OP_LOAD: begin
                    row_q <= i_load;
                end
                OP_PIVOT: begin
                    row_q <= i_norm;
                end
                OP_ELIM: begin
                    for (int j = 0; j < N_COL; j++) begin
                        row_q[j] <= fix_t'(row_q[j] - prod[j]);
                    end
                    row_q[i_step] <= '0;
                end
                default: begin
                    row_q <= row_q;
                end
            endcase
        end
    end

    assign o_row = row_q;

endmodule

// File: source/fix_div.sv
module fix_div (
    input  fixp_pkg::fix_t i_num,
    input  fixp_pkg::fix_t i_den,
    output fixp_pkg::fix_t o_q
);
    import fixp_pkg::*;

    logic signed [FIX_W+FRAC_W-1:0] num_ext;
    logic signed [FIX_W+FRAC_W-1:0] quot;
    fix_t                           den_safe;
    fix_t                           kept;
    logic                           den_zero;
    logic                           ovf;

    always_comb begin
        den_zero = (i_den == '0);
        // keep the divider away from a zero divisor
        den_safe = den_zero ? FIX_ONE : i_den;
        num_ext  = {i_num, {FRAC_W{1'b0}}};
        quot     = num_ext / den_safe;
        kept     = quot[FIX_W-1:0];
        ovf      = quot[FIX_W+FRAC_W-1:FIX_W] != {FRAC_W{kept[FIX_W-1]}};
        if (den_zero) begin
            o_q = i_num[FIX_W-1] ? FIX_MIN : FIX_MAX;
        end else if (ovf) begin
            o_q = (i_num[FIX_W-1] ^ i_den[FIX_W-1]) ? FIX_MIN : FIX_MAX;
        end else begin
            o_q = kept;
        end
    end

endmodule

// File: source/fix_mul.sv
module fix_mul (
    input  fixp_pkg::fix_t i_a,
    input  fixp_pkg::fix_t i_b,
    output fixp_pkg::fix_t o_p
);
    import fixp_pkg::*;

    logic signed [2*FIX_W-1:0] prod;
    fix_t                      kept;
    logic                      ovf;

    always_comb begin
        prod = i_a * i_b;
        kept = prod[FIX_W+FRAC_W-1:FRAC_W];
        // dropped high bits must all repeat the kept sign
        ovf  = prod[2*FIX_W-1:FIX_W+FRAC_W] != {INT_W{kept[FIX_W-1]}};
        if (ovf) begin
            o_p = (i_a[FIX_W-1] ^ i_b[FIX_W-1]) ? FIX_MIN : FIX_MAX;
        end else begin
            o_p = kept;
        end
    end

endmodule

// File: source/fixp_pkg.sv
package fixp_pkg;

    // signed fixed point, INT_W integer bits and FRAC_W fraction bits
    localparam int INT_W  = 20;
    localparam int FRAC_W = 13;
    localparam int FIX_W  = INT_W + FRAC_W;

    typedef logic signed [FIX_W-1:0] fix_t;

    // 1.0 is 2**FRAC_W
    localparam fix_t FIX_ONE = fix_t'(1) <<< FRAC_W;

    // saturation limits
    localparam fix_t FIX_MAX = {1'b0, {(FIX_W-1){1'b1}}};
    localparam fix_t FIX_MIN = {1'b1, {(FIX_W-1){1'b0}}};

endpackage

// File: source/persp_pkg.sv
package persp_pkg;

    // source image coordinates
    localparam int COORD_W = 10;

    typedef logic [COORD_W-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    typedef struct packed {
        point_t ul;
        point_t ur;
        point_t dr;
        point_t dl;
    } quad_t;

    // destination square is DST_SIZE on each side
    localparam int DST_SIZE = 99;

    // 8 unknowns, augmented with one right-hand column
    localparam int N_UNK   = 8;
    localparam int N_COL   = 9;
    localparam int RHS_COL = 8;

    typedef fixp_pkg::fix_t [N_COL-1:0] row_t;

    typedef struct packed {
        fixp_pkg::fix_t a;
        fixp_pkg::fix_t b;
        fixp_pkg::fix_t c;
        fixp_pkg::fix_t d;
        fixp_pkg::fix_t e;
        fixp_pkg::fix_t f;
        fixp_pkg::fix_t g;
        fixp_pkg::fix_t h;
    } coef_t;

    // pivot column, also the pivot lane
    typedef logic [2:0] step_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_SOLVE,
        S_DONE
    } ctl_state_e;

    typedef enum logic [1:0] {
        OP_HOLD,
        OP_LOAD,
        OP_PIVOT,
        OP_ELIM
    } lane_op_e;

endpackage

// File: source/persp_solver.sv
module persp_solver (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_start,
    input  persp_pkg::quad_t i_quad,
    output persp_pkg::coef_t o_coef,
    output logic             o_valid
);
    import persp_pkg::*;

    row_t     [N_UNK-1:0] load_rows;
    row_t     [N_UNK-1:0] lane_rows;
    lane_op_e [N_UNK-1:0] lane_ops;
    step_t                step;
    row_t                 norm_row;
    logic                 done;

    system_builder u_builder (
        .i_quad (i_quad),
        .o_rows (load_rows)
    );

    solve_ctrl u_ctrl (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (i_start),
        .o_ops   (lane_ops),
        .o_step  (step),
        .o_done  (done)
    );

    pivot_normalizer u_norm (
        .i_rows (lane_rows),
        .i_step (step),
        .o_norm (norm_row)
    );

    // one lane per matrix row
    for (genvar k = 0; k < N_UNK; k++) begin : g_lane
        elim_lane u_lane (
            .i_clk   (i_clk),
            .i_rst_n (i_rst_n),
            .i_op    (lane_ops[k]),
            .i_step  (step),
            .i_load  (load_rows[k]),
            .i_norm  (norm_row),
            .o_row   (lane_rows[k])
        );
    end

    solution_collect u_collect (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_done  (done),
        .i_rows  (lane_rows),
        .o_coef  (o_coef),
        .o_valid (o_valid)
    );

endmodule

// File: source/pivot_normalizer.sv
module pivot_normalizer (
    input  persp_pkg::row_t [persp_pkg::N_UNK-1:0] i_rows,
    input  persp_pkg::step_t                      i_step,
    output persp_pkg::row_t                       o_norm
);
    import fixp_pkg::*;
    import persp_pkg::*;

    row_t piv_row;
    fix_t piv;
    row_t quot;

    assign piv_row = i_rows[i_step];
    assign piv     = piv_row[i_step];

    for (genvar j = 0; j < N_COL; j++) begin : g_div
        fix_div u_div (
            .i_num (piv_row[j]),
            .i_den (piv),
            .o_q   (quot[j])
        );
    end

    // pivot entry is exactly one after scaling
    always_comb begin
        o_norm         = quot;
        o_norm[i_step] = FIX_ONE;
    end

endmodule

// File: source/solution_collect.sv
module solution_collect (
    input  logic                                  i_clk,
    input  logic                                  i_rst_n,
    input  logic                                  i_done,
    input  persp_pkg::row_t [persp_pkg::N_UNK-1:0] i_rows,
    output persp_pkg::coef_t                      o_coef,
    output logic                                  o_valid
);
    import persp_pkg::*;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_coef  <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_done;
            // lane k holds unknown k in its right-hand column
            if (i_done) begin
                o_coef.a <= i_rows[0][RHS_COL];
                o_coef.b <= i_rows[1][RHS_COL];
                o_coef.c <= i_rows[2][RHS_COL];
                o_coef.d <= i_rows[3][RHS_COL];
                o_coef.e <= i_rows[4][RHS_COL];
                o_coef.f <= i_rows[5][RHS_COL];
                o_coef.g <= i_rows[6][RHS_COL];
                o_coef.h <= i_rows[7][RHS_COL];
            end
        end
    end

endmodule

// File: source/solve_ctrl.sv
module solve_ctrl (
    input  logic                                     i_clk,
    input  logic                                     i_rst_n,
    input  logic                                     i_start,
    output persp_pkg::lane_op_e [persp_pkg::N_UNK-1:0] o_ops,
    output persp_pkg::step_t                         o_step,
    output logic                                     o_done
);
    import persp_pkg::*;

    ctl_state_e state;
    step_t      step;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= S_IDLE;
            step  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (i_start) begin
                        state <= S_SOLVE;
                        step  <= '0;
                    end
                end
                S_SOLVE: begin
                    step <= step + 1'b1;
                    if (step == step_t'(N_UNK - 1)) begin
                        state <= S_DONE;
                    end
                end
                S_DONE: begin
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // load happens on the accepting edge itself
    always_comb begin
        for (int i = 0; i < N_UNK; i++) begin
            o_ops[i] = OP_HOLD;
            if (state == S_IDLE && i_start) begin
                o_ops[i] = OP_LOAD;
            end else if (state == S_SOLVE) begin
                o_ops[i] = (step_t'(i) == step) ? OP_PIVOT : OP_ELIM;
            end
        end
    end

    assign o_step = step;
    assign o_done = (state == S_DONE);

endmodule

// File: source/system_builder.sv
module system_builder (
    input  persp_pkg::quad_t                      i_quad,
    output persp_pkg::row_t [persp_pkg::N_UNK-1:0] o_rows
);
    import fixp_pkg::*;
    import persp_pkg::*;

    localparam int DST_BITS = $clog2(DST_SIZE + 1);

    function automatic fix_t to_fix(logic signed [INT_W-1:0] n);
        return {n, {FRAC_W{1'b0}}};
    endfunction

    // constant multiply by DST_SIZE as shift and add
    function automatic logic signed [INT_W-1:0] times_dst(coord_t c);
        logic signed [INT_W-1:0] w;
        logic signed [INT_W-1:0] acc;
        w   = signed'({{(INT_W-COORD_W){1'b0}}, c});
        acc = '0;
        for (int b = 0; b < DST_BITS; b++) begin
            if (DST_SIZE[b]) begin
                acc = acc + (w <<< b);
            end
        end
        return acc;
    endfunction

    // one equation of corner p at destination (u_hi, v_hi) scaled by DST_SIZE
    function automatic row_t make_row(point_t p, logic is_y, logic u_hi, logic v_hi);
        row_t                    r;
        coord_t                  s;
        logic signed [INT_W-1:0] u;
        logic signed [INT_W-1:0] v;
        logic signed [INT_W-1:0] us;
        logic signed [INT_W-1:0] vs;
        int                      base;
        s    = is_y ? p.y : p.x;
        u    = u_hi ? INT_W'(DST_SIZE) : '0;
        v    = v_hi ? INT_W'(DST_SIZE) : '0;
        us   = u_hi ? times_dst(s) : '0;
        vs   = v_hi ? times_dst(s) : '0;
        base = is_y ? 3 : 0;
        r    = '0;
        r[base]     = to_fix(u);
        r[base + 1] = to_fix(v);
        r[base + 2] = FIX_ONE;
        r[6]        = to_fix(-us);
        r[7]        = to_fix(-vs);
        r[RHS_COL]  = to_fix(signed'({{(INT_W-COORD_W){1'b0}}, s}));
        return r;
    endfunction

    // lane order keeps every starting diagonal entry nonzero
    always_comb begin
        o_rows[0] = make_row(i_quad.ur, 1'b0, 1'b1, 1'b0);
        o_rows[1] = make_row(i_quad.dl, 1'b0, 1'b0, 1'b1);
        o_rows[2] = make_row(i_quad.ul, 1'b0, 1'b0, 1'b0);
        o_rows[3] = make_row(i_quad.ur, 1'b1, 1'b1, 1'b0);
        o_rows[4] = make_row(i_quad.dl, 1'b1, 1'b0, 1'b1);
        o_rows[5] = make_row(i_quad.ul, 1'b1, 1'b0, 1'b0);
        o_rows[6] = make_row(i_quad.dr, 1'b0, 1'b1, 1'b1);
        o_rows[7] = make_row(i_quad.dr, 1'b1, 1'b1, 1'b1);
    end

endmodule
